//--- src/dds_pkg.sv
package dds_pkg;

    // Phase bits seen by the waveform block, set by the LUT addressing
    localparam int PHASE_W = 12;

    // Signed triangle and output sample width
    localparam int WAVE_W = 21;

    // Quarter-wave ramp, entry i holds i * 4096
    localparam int LUT_DEPTH = 256;

    // Unsigned gain where 128 is unity
    localparam int GAIN_W = 8;

    // Sample tick divider width
    localparam int DIV_W = 16;

    // Wishbone word addresses
    typedef enum logic [2:0] {
        REG_CTRL      = 3'd0,
        REG_PHASE_INC = 3'd1,
        REG_DIVIDER   = 3'd2,
        REG_GAIN      = 3'd3,
        REG_STATUS    = 3'd4
    } reg_addr_e;

    typedef enum logic {
        BUS_IDLE = 1'b0,
        BUS_ACK  = 1'b1
    } bus_state_e;

endpackage

//--- src/dds_ctrl.sv
`timescale 1ns/1ps

module dds_ctrl #(
    parameter int ACC_W = 32
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      wb_cyc,
    input  logic                                      wb_stb,
    input  logic                                      wb_we,
    input  logic [$bits(dds_pkg::reg_addr_e)-1:0]     wb_adr,
    input  logic [31:0]                               wb_dat_w,
    output logic [31:0]                               wb_dat_r,
    output logic                                      wb_ack,
    input  logic                                      sample_valid,
    output logic                                      enable,
    output logic [ACC_W-1:0]                          phase_inc,
    output logic [dds_pkg::DIV_W-1:0]                 divider,
    output logic [dds_pkg::GAIN_W-1:0]                gain
);
    import dds_pkg::*;

    localparam logic [GAIN_W-1:0] GAIN_UNITY = 1 << (GAIN_W - 1);

    bus_state_e bus_state;
    reg_addr_e  addr;
    logic       bus_req;
    logic       wr_en;
    logic [31:0] sample_count;

    assign addr    = reg_addr_e'(wb_adr);
    assign bus_req = wb_cyc && wb_stb;

    // Registers update on the edge that raises ack
    assign wr_en  = (bus_state == BUS_IDLE) && bus_req && wb_we;
    assign wb_ack = (bus_state == BUS_ACK);

    always_ff @(posedge clk) begin
        if (rst) begin
            bus_state <= BUS_IDLE;
        end else begin
            case (bus_state)
                BUS_IDLE: begin
                    if (bus_req) begin
                        bus_state <= BUS_ACK;
                    end
                end
                BUS_ACK: begin
                    bus_state <= BUS_IDLE;
                end
                default: begin
                    bus_state <= BUS_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            enable    <= 1'b0;
            phase_inc <= '0;
            divider   <= '0;
            gain      <= GAIN_UNITY;
        end else if (wr_en) begin
            case (addr)
                REG_CTRL:      enable    <= wb_dat_w[0];
                REG_PHASE_INC: phase_inc <= wb_dat_w[ACC_W-1:0];
                REG_DIVIDER:   divider   <= wb_dat_w[DIV_W-1:0];
                REG_GAIN:      gain      <= wb_dat_w[GAIN_W-1:0];
                default: begin
                end
            endcase
        end
    end

    // Free-running count of samples that left the scaler
    always_ff @(posedge clk) begin
        if (rst) begin
            sample_count <= '0;
        end else if (sample_valid) begin
            sample_count <= sample_count + 32'd1;
        end
    end

    // Master holds the address through ack
    always_comb begin
        case (addr)
            REG_CTRL:      wb_dat_r = {31'b0, enable};
            REG_PHASE_INC: wb_dat_r = 32'(phase_inc);
            REG_DIVIDER:   wb_dat_r = 32'(divider);
            REG_GAIN:      wb_dat_r = 32'(gain);
            REG_STATUS:    wb_dat_r = sample_count;
            default:       wb_dat_r = '0;
        endcase
    end

    a_ack_in_cycle: assert property (
        @(posedge clk) disable iff (rst)
        wb_ack |-> (wb_cyc && wb_stb)
    );

    a_ack_single: assert property (
        @(posedge clk) disable iff (rst)
        wb_ack |=> !wb_ack
    );

endmodule

//--- src/phase_accumulator.sv
`timescale 1ns/1ps

module phase_accumulator #(
    parameter int ACC_W = 32
) (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          enable,
    input  logic [ACC_W-1:0]              phase_inc,
    input  logic [dds_pkg::DIV_W-1:0]     divider,
    output logic [dds_pkg::PHASE_W-1:0]   phase,
    output logic                          phase_valid
);
    import dds_pkg::*;

    logic [DIV_W-1:0] tick_cnt;
    logic [ACC_W-1:0] acc;
    logic             tick;

    // Also catches a divider lowered below the running count
    assign tick = (tick_cnt >= divider);

    always_ff @(posedge clk) begin
        if (rst || !enable) begin
            tick_cnt <= '0;
            acc      <= '0;
        end else if (tick) begin
            tick_cnt <= '0;
            acc      <= acc + phase_inc;
        end else begin
            tick_cnt <= tick_cnt + 1'b1;
        end
    end

    // Pulse k carries k * phase_inc before the add on the same edge
    assign phase_valid = enable && tick;
    assign phase       = acc[ACC_W-1 -: PHASE_W];

    a_tick_in_range: assert property (
        @(posedge clk) disable iff (rst)
        (enable && $stable(divider)) |-> (tick_cnt <= divider)
    );

endmodule

//--- src/triangle_lut.sv
`timescale 1ns/1ps

module triangle_lut (
    input  logic                         clk,
    input  logic                         ena,
    input  logic [7:0]                   addra,
    input  logic                         enb,
    input  logic [7:0]                   addrb,
    output logic [dds_pkg::WAVE_W-1:0]   douta,
    output logic [dds_pkg::WAVE_W-1:0]   doutb
);
    import dds_pkg::*;

    // Slope of the ramp per entry
    localparam int RAMP_STEP = 4096;

    logic [WAVE_W-1:0] rom [LUT_DEPTH];

    for (genvar i = 0; i < LUT_DEPTH; i++) begin : g_rom
        assign rom[i] = WAVE_W'(i * RAMP_STEP);
    end

    always_ff @(posedge clk) begin
        if (ena) begin
            douta <= rom[addra];
        end
        if (enb) begin
            doutb <= rom[addrb];
        end
    end

endmodule

//--- src/triangle_wave.sv
`timescale 1ns/1ps

module triangle_wave (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                in_valid,
    input  logic [dds_pkg::PHASE_W-1:0]         phase,
    output logic signed [dds_pkg::WAVE_W-1:0]   wave,
    output logic                                out_valid
);
    import dds_pkg::*;

    localparam int SUM_W = WAVE_W + 4;

    // Largest magnitude the ramp can reach
    localparam int PEAK = (LUT_DEPTH - 1) * 4096;

    logic [PHASE_W-1:0]       phase_next;
    logic [7:0]               addr_cur;
    logic [7:0]               addr_next;
    logic [WAVE_W-1:0]        lut_cur;
    logic [WAVE_W-1:0]        lut_next;
    logic                     sign_cur;
    logic [1:0]               residue;
    logic                     valid_s1;
    logic signed [WAVE_W-1:0] val_cur;
    logic signed [WAVE_W-1:0] val_next;
    logic signed [3:0]        w_cur;
    logic signed [3:0]        w_next;
    logic signed [SUM_W-1:0]  sum;

    // Last step of a quarter pairs with itself
    assign phase_next = (phase[9:2] != 8'hff) ? phase + PHASE_W'(4) : phase;

    // Odd quarters walk the ramp backwards
    assign addr_cur  = phase[10] ? 8'hff - phase[9:2] : phase[9:2];
    assign addr_next = phase[10] ? 8'hff - phase_next[9:2] : phase_next[9:2];

    triangle_lut triangle_lut_inst (
        .clk   (clk),
        .ena   (in_valid),
        .addra (addr_cur),
        .enb   (in_valid),
        .addrb (addr_next),
        .douta (lut_cur),
        .doutb (lut_next)
    );

    // Next step never leaves the half period, so one sign serves both
    always_ff @(posedge clk) begin
        if (in_valid) begin
            sign_cur <= phase[11];
            residue  <= phase[1:0];
        end
    end

    assign val_cur  = sign_cur ? -$signed(lut_cur) : $signed(lut_cur);
    assign val_next = sign_cur ? -$signed(lut_next) : $signed(lut_next);

    assign w_next = $signed({2'b00, residue});
    assign w_cur  = 4'sd4 - w_next;

    always_ff @(posedge clk) begin
        if (valid_s1) begin
            sum <= val_cur * w_cur + val_next * w_next;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            valid_s1  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            valid_s1  <= in_valid;
            out_valid <= valid_s1;
        end
    end

    // Weights sum to 4, so drop two bits
    assign wave = sum[WAVE_W+1:2];

    a_wave_in_range: assert property (
        @(posedge clk) disable iff (rst)
        out_valid |-> (wave <= PEAK && wave >= -PEAK)
    );

endmodule

//--- src/amplitude_scaler.sv
`timescale 1ns/1ps

module amplitude_scaler (
    input  logic                                clk,
    input  logic                                rst,
    input  logic                                in_valid,
    input  logic signed [dds_pkg::WAVE_W-1:0]   wave,
    input  logic [dds_pkg::GAIN_W-1:0]          gain,
    output logic signed [dds_pkg::WAVE_W-1:0]   sample,
    output logic                                sample_valid
);
    import dds_pkg::*;

    localparam int PROD_W = WAVE_W + GAIN_W + 1;

    logic signed [PROD_W-1:0] product;
    logic signed [PROD_W-1:0] scaled;

    // Gain is unsigned so it gets a zero sign bit
    assign product = wave * $signed({1'b0, gain});

    // Seven fraction bits of gain dropped by flooring
    assign scaled = product >>> (GAIN_W - 1);

    always_ff @(posedge clk) begin
        if (in_valid) begin
            sample <= scaled[WAVE_W-1:0];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            sample_valid <= 1'b0;
        end else begin
            sample_valid <= in_valid;
        end
    end

endmodule

//--- src/dds_synth.sv
`timescale 1ns/1ps

module dds_synth #(
    parameter int ACC_W = 32
) (
    input  logic                                    clk,
    input  logic                                    rst,
    input  logic                                    wb_cyc,
    input  logic                                    wb_stb,
    input  logic                                    wb_we,
    input  logic [$bits(dds_pkg::reg_addr_e)-1:0]   wb_adr,
    input  logic [31:0]                             wb_dat_w,
    output logic [31:0]                             wb_dat_r,
    output logic                                    wb_ack,
    output logic signed [dds_pkg::WAVE_W-1:0]       sample,
    output logic                                    sample_valid
);
    import dds_pkg::*;

    logic                     enable;
    logic [ACC_W-1:0]         phase_inc;
    logic [DIV_W-1:0]         divider;
    logic [GAIN_W-1:0]        gain;
    logic [PHASE_W-1:0]       phase;
    logic                     phase_valid;
    logic signed [WAVE_W-1:0] wave;
    logic                     wave_valid;

    dds_ctrl #(
        .ACC_W (ACC_W)
    ) dds_ctrl_inst (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .sample_valid (sample_valid),
        .enable       (enable),
        .phase_inc    (phase_inc),
        .divider      (divider),
        .gain         (gain)
    );

    phase_accumulator #(
        .ACC_W (ACC_W)
    ) phase_accumulator_inst (
        .clk         (clk),
        .rst         (rst),
        .enable      (enable),
        .phase_inc   (phase_inc),
        .divider     (divider),
        .phase       (phase),
        .phase_valid (phase_valid)
    );

    triangle_wave triangle_wave_inst (
        .clk       (clk),
        .rst       (rst),
        .in_valid  (phase_valid),
        .phase     (phase),
        .wave      (wave),
        .out_valid (wave_valid)
    );

    amplitude_scaler amplitude_scaler_inst (
        .clk          (clk),
        .rst          (rst),
        .in_valid     (wave_valid),
        .wave         (wave),
        .gain         (gain),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

endmodule

//--- sim/dds_synth_tb.sv
`timescale 1ns/1ps

module dds_synth_tb;
    import dds_pkg::*;

    localparam int ACC_W          = 32;
    localparam int CLK_PERIOD     = 100;
    localparam int DRIVE_DELAY    = 10;
    localparam int TIMEOUT_CYCLES = 200;

    logic                     clk;
    logic                     rst;
    logic                     wb_cyc;
    logic                     wb_stb;
    logic                     wb_we;
    logic [2:0]               wb_adr;
    logic [31:0]              wb_dat_w;
    logic [31:0]              wb_dat_r;
    logic                     wb_ack;
    logic signed [WAVE_W-1:0] sample;
    logic                     sample_valid;

    logic signed [WAVE_W-1:0] sample_q[$];
    int                       stamp_q[$];
    int                       cycle_count = 0;
    int                       samples_seen = 0;
    int                       errors = 0;
    int                       test_errors_base = 0;
    int                       tests_passed = 0;
    int                       tests_failed = 0;
    logic [31:0]              rng_state = 32'h5fe7_783e;

    dds_synth #(
        .ACC_W (ACC_W)
    ) dds_synth_inst (
        .clk          (clk),
        .rst          (rst),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack),
        .sample       (sample),
        .sample_valid (sample_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Every sample is queued with the cycle it was seen in
    always @(negedge clk) begin
        cycle_count++;
        if (!rst && sample_valid) begin
            sample_q.push_back(sample);
            stamp_q.push_back(cycle_count);
            samples_seen++;
        end
    end

    initial begin
        #(20_000 * CLK_PERIOD);
        $display("time limit reached before the tests finished");
        $display("Simulation FAILED");
        $finish;
    end

    function automatic logic [31:0] next_random(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    // Phase of pulse k is the top bits of k * inc
    function automatic logic [PHASE_W-1:0] expected_phase(input logic [31:0] inc, input int k);
        logic [ACC_W-1:0] acc;
        acc = inc * ACC_W'(k);
        return acc[ACC_W-1 -: PHASE_W];
    endfunction

    function automatic logic signed [WAVE_W-1:0] expected_wave(input logic [PHASE_W-1:0] p);
        logic [PHASE_W-1:0] p_next;
        int step_cur;
        int step_next;
        int v_cur;
        int v_next;
        int r;
        int sum;
        p_next = (p[9:2] != 8'hff) ? p + 12'd4 : p;
        step_cur = p[10] ? 255 - int'(p[9:2]) : int'(p[9:2]);
        step_next = p[10] ? 255 - int'(p_next[9:2]) : int'(p_next[9:2]);
        v_cur = p[11] ? -(step_cur * 4096) : step_cur * 4096;
        v_next = p_next[11] ? -(step_next * 4096) : step_next * 4096;
        r = int'(p[1:0]);
        sum = v_cur * (4 - r) + v_next * r;
        return WAVE_W'(sum >>> 2);
    endfunction

    function automatic logic signed [WAVE_W-1:0] expected_sample(
        input logic signed [WAVE_W-1:0] w,
        input logic [GAIN_W-1:0] g
    );
        longint prod;
        prod = longint'(w) * longint'(g);
        prod = prod >>> 7;
        return prod[WAVE_W-1:0];
    endfunction

    task automatic check_sample(input string name, input logic signed [WAVE_W-1:0] expected,
                                input logic signed [WAVE_W-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_reg(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected 0x%08h actual 0x%08h", name, expected, actual);
            errors++;
        end
    endtask

    task automatic check_gap(input string name, input logic [DIV_W-1:0] expected,
                             input logic [DIV_W-1:0] actual);
        if (actual !== expected) begin
            $display("mismatch %s expected %0d actual %0d", name, expected, actual);
            errors++;
        end
    endtask

    task automatic wb_write(input logic [2:0] adr, input logic [31:0] data);
        int n;
        n = 0;
        @(posedge clk);
        #DRIVE_DELAY;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_adr   = adr;
        wb_dat_w = data;
        @(negedge clk);
        while (!wb_ack && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (!wb_ack) begin
            $display("no ack came for the write to address %0d", adr);
            errors++;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
    endtask

    task automatic wb_read(input logic [2:0] adr, output logic [31:0] data);
        int n;
        n = 0;
        data = '0;
        @(posedge clk);
        #DRIVE_DELAY;
        wb_cyc = 1'b1;
        wb_stb = 1'b1;
        wb_we  = 1'b0;
        wb_adr = adr;
        @(negedge clk);
        while (!wb_ack && n < TIMEOUT_CYCLES) begin
            @(negedge clk);
            n++;
        end
        if (wb_ack) begin
            data = wb_dat_r;
        end else begin
            $display("no ack came for the read of address %0d", adr);
            errors++;
        end
        @(posedge clk);
        #DRIVE_DELAY;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
    endtask

    task automatic wait_sample(output logic signed [WAVE_W-1:0] value, output int stamp,
                               output bit got);
        int n;
        n = 0;
        got = 1'b0;
        value = '0;
        stamp = 0;
        while (!got && n < TIMEOUT_CYCLES) begin
            if (sample_q.size() > 0) begin
                value = sample_q.pop_front();
                stamp = stamp_q.pop_front();
                got = 1'b1;
            end else begin
                @(negedge clk);
                n++;
            end
        end
        if (!got) begin
            $display("sample_valid did not arrive in time");
            errors++;
        end
    endtask

    // Leftover samples in flight are counted by the DUT but not checked
    task automatic stop_and_drain();
        wb_write(REG_CTRL, 32'd0);
        repeat (10) @(posedge clk);
        sample_q.delete();
        stamp_q.delete();
    endtask

    task automatic run_stream(input string name, input logic [31:0] inc,
                              input logic [DIV_W-1:0] div, input logic [GAIN_W-1:0] g,
                              input int count, input bit check_spacing);
        logic signed [WAVE_W-1:0] value;
        logic signed [WAVE_W-1:0] wave_exp;
        int stamp;
        int prev_stamp;
        bit got;
        wb_write(REG_PHASE_INC, inc);
        wb_write(REG_DIVIDER, 32'(div));
        wb_write(REG_GAIN, 32'(g));
        wb_write(REG_CTRL, 32'd1);
        prev_stamp = 0;
        for (int k = 0; k < count; k++) begin
            wait_sample(value, stamp, got);
            if (!got) begin
                break;
            end
            wave_exp = expected_wave(expected_phase(inc, k));
            check_sample($sformatf("%s sample %0d", name, k), expected_sample(wave_exp, g),
                         value);
            if (check_spacing && k > 0) begin
                check_gap($sformatf("%s gap %0d", name, k), DIV_W'(int'(div) + 1),
                          DIV_W'(stamp - prev_stamp));
            end
            prev_stamp = stamp;
        end
        stop_and_drain();
    endtask

    task automatic begin_test();
        test_errors_base = errors;
    endtask

    task automatic report_test(input string name);
        if (errors == test_errors_base) begin
            $display("%s: pass", name);
            tests_passed++;
        end else begin
            $display("%s: fail with %0d errors", name, errors - test_errors_base);
            tests_failed++;
        end
    endtask

    task automatic test_registers();
        logic [31:0] data;
        begin_test();
        wb_read(REG_CTRL, data);
        check_reg("ctrl default", 32'd0, data);
        wb_read(REG_PHASE_INC, data);
        check_reg("phase_inc default", 32'd0, data);
        wb_read(REG_DIVIDER, data);
        check_reg("divider default", 32'd0, data);
        wb_read(REG_GAIN, data);
        check_reg("gain default", 32'd128, data);
        wb_read(REG_STATUS, data);
        check_reg("status default", 32'd0, data);
        wb_write(REG_PHASE_INC, 32'h1234_5678);
        wb_read(REG_PHASE_INC, data);
        check_reg("phase_inc readback", 32'h1234_5678, data);
        wb_write(REG_DIVIDER, 32'h0000_beef);
        wb_read(REG_DIVIDER, data);
        check_reg("divider readback", 32'h0000_beef, data);
        wb_write(REG_GAIN, 32'h0000_005a);
        wb_read(REG_GAIN, data);
        check_reg("gain readback", 32'h0000_005a, data);
        wb_write(3'd5, 32'hffff_ffff);
        wb_read(3'd5, data);
        check_reg("unmapped readback", 32'd0, data);
        wb_read(3'd7, data);
        check_reg("unmapped read", 32'd0, data);
        wb_write(REG_GAIN, 32'd128);
        wb_write(REG_DIVIDER, 32'd0);
        wb_write(REG_PHASE_INC, 32'd0);
        report_test("register defaults and readback");
    endtask

    task automatic test_random_and_count();
        logic [31:0] data;
        begin_test();
        for (int i = 0; i < 8; i++) begin
            rng_state = next_random(rng_state);
            run_stream($sformatf("random inc %0d", i), rng_state, 16'd0, 8'd128, 20, 1'b0);
        end
        wb_read(REG_STATUS, data);
        check_reg("sample count", 32'(samples_seen), data);
        report_test("random increments and sample count");
    endtask

    initial begin
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (2) @(posedge clk);
        #DRIVE_DELAY;
        rst = 1'b0;

        test_registers();

        begin_test();
        run_stream("unity triangle", 32'h0400_0000, 16'd0, 8'd128, 80, 1'b0);
        report_test("triangle sequence at unity gain");

        begin_test();
        run_stream("residue", 32'h0050_0000, 16'd0, 8'd128, 60, 1'b0);
        report_test("interpolation residue");

        begin_test();
        run_stream("spacing", 32'h0123_4567, 16'd9, 8'd128, 12, 1'b1);
        report_test("sample spacing");

        begin_test();
        run_stream("gain 64", 32'h0400_0000, 16'd0, 8'd64, 64, 1'b0);
        run_stream("gain 200", 32'h0400_0000, 16'd0, 8'd200, 64, 1'b0);
        run_stream("gain 0", 32'h0400_0000, 16'd0, 8'd0, 64, 1'b0);
        report_test("gain scaling");

        test_random_and_count();

        $display("tests passed %0d, tests failed %0d", tests_passed, tests_failed);
        if (errors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- dds_synth.f
src/dds_pkg.sv
src/dds_ctrl.sv
src/phase_accumulator.sv
src/triangle_lut.sv
src/triangle_wave.sv
src/amplitude_scaler.sv
src/dds_synth.sv
sim/dds_synth_tb.sv

//--- Makefile
TOP = dds_synth_tb
LOG = sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module dds_synth -f dds_synth.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f dds_synth.f -Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "testbench reported failure"; \
		exit 1; \
	fi
	@grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
